// File: mips_exc_pkg.sv
package mips_exc_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  exc_code_t;
    typedef logic [7:0]  irq_t;
    typedef logic [4:0]  cp0_addr_t;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } size_t;

    // Cause.ExcCode values
    localparam exc_code_t EXC_INT  = 5'd0;
    localparam exc_code_t EXC_ADEL = 5'd4;
    localparam exc_code_t EXC_ADES = 5'd5;
    localparam exc_code_t EXC_SYS  = 5'd8;
    localparam exc_code_t EXC_RI   = 5'd10;

    // CP0 register numbers, select 0 except EBase (sel 1 on real cores)
    localparam cp0_addr_t CP0_BADVADDR = 5'd8;
    localparam cp0_addr_t CP0_STATUS   = 5'd12;
    localparam cp0_addr_t CP0_CAUSE    = 5'd13;
    localparam cp0_addr_t CP0_EPC      = 5'd14;
    localparam cp0_addr_t CP0_EBASE    = 5'd15;

    // Exception vectors
    localparam word_t BOOT_EXC_BASE   = 32'hBFC0_0200;
    localparam word_t VEC_GENERAL_OFS = 32'h0000_0180;
    localparam word_t VEC_INT_OFS     = 32'h0000_0200;

    // Field positions in Status and Cause
    localparam int STATUS_IE_BIT  = 0;
    localparam int STATUS_EXL_BIT = 1;
    localparam int STATUS_BEV_BIT = 22;
    localparam int CAUSE_IV_BIT   = 23;
    localparam int CAUSE_BD_BIT   = 31;

    // Reset values
    localparam word_t RESET_PC_DEFAULT    = 32'hBFC0_0000;
    localparam word_t EBASE_RESET_DEFAULT = 32'h8000_0000;

endpackage

// File: addr_check.sv
`timescale 1ns/1ps

module addr_check (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 inst_valid,
    input  mips_exc_pkg::word_t  pc,
    input  logic                 in_delayslot,
    input  logic                 syscall,
    input  logic                 eret,
    input  logic                 invalid_inst,
    input  logic                 mem_read,
    input  logic                 mem_write,
    input  mips_exc_pkg::size_t  mem_size,
    input  mips_exc_pkg::word_t  mem_vaddr,
    output logic                 is_real_inst,
    output mips_exc_pkg::word_t  pc_value,
    output logic                 in_delayslot_q,
    output logic                 syscall_q,
    output logic                 eret_q,
    output logic                 invalid_inst_q,
    output logic                 data_we,
    output mips_exc_pkg::word_t  mem_access_vaddr,
    output logic                 iaddr_exp_illegal,
    output logic                 daddr_exp_illegal
);
    import mips_exc_pkg::*;

    logic iaddr_bad;
    logic size_misaligned;
    logic daddr_bad;

    assign iaddr_bad = (pc[1:0] != 2'b00);

    always_comb begin
        case (mem_size)
            SIZE_HALF: size_misaligned = mem_vaddr[0];
            SIZE_WORD: size_misaligned = (mem_vaddr[1:0] != 2'b00);
            default:   size_misaligned = 1'b0; // Byte access never faults
        endcase
    end

    assign daddr_bad = (mem_read | mem_write) & size_misaligned;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            is_real_inst      <= 1'b0;
            in_delayslot_q    <= 1'b0;
            syscall_q         <= 1'b0;
            eret_q            <= 1'b0;
            invalid_inst_q    <= 1'b0;
            data_we           <= 1'b0;
            iaddr_exp_illegal <= 1'b0;
            daddr_exp_illegal <= 1'b0;
        end else begin
            is_real_inst      <= inst_valid;
            in_delayslot_q    <= inst_valid & in_delayslot;
            syscall_q         <= inst_valid & syscall;
            eret_q            <= inst_valid & eret;
            invalid_inst_q    <= inst_valid & invalid_inst;
            data_we           <= inst_valid & mem_write;
            iaddr_exp_illegal <= inst_valid & iaddr_bad;
            daddr_exp_illegal <= inst_valid & daddr_bad;
        end
    end

    always_ff @(posedge clk) begin
        pc_value         <= pc;
        mem_access_vaddr <= mem_vaddr;
    end

endmodule

// File: exception.sv
`timescale 1ns/1ps

module exception (
    input  logic                     is_real_inst,
    input  mips_exc_pkg::word_t      pc_value,
    input  logic                     in_delayslot,
    input  logic                     syscall,
    input  logic                     eret,
    input  logic                     invalid_inst,
    input  logic                     data_we,
    input  mips_exc_pkg::word_t      mem_access_vaddr,
    input  logic                     iaddr_exp_illegal,
    input  logic                     daddr_exp_illegal,
    input  mips_exc_pkg::irq_t       interrupt_flags,
    input  logic                     allow_int,
    input  logic [19:0]              ebase_in,
    input  mips_exc_pkg::word_t      epc_in,
    input  logic                     special_int_vec,
    input  logic                     boot_exp_vec,
    output logic                     flush,
    output logic                     cp0_wr_exp,
    output logic                     cp0_clean_exl,
    output mips_exc_pkg::word_t      exp_epc,
    output mips_exc_pkg::exc_code_t  exp_code,
    output mips_exc_pkg::word_t      exp_bad_vaddr,
    output logic                     cp0_badv_we,
    output mips_exc_pkg::word_t      exception_new_pc
);
    import mips_exc_pkg::*;

    word_t exception_base;
    logic  int_taken;

    assign exception_base = boot_exp_vec ? BOOT_EXC_BASE : {ebase_in, 12'h000};
    assign int_taken      = is_real_inst & allow_int & (interrupt_flags != '0);

    // Strict priority, one event per instruction
    always_comb begin
        flush            = 1'b1;
        cp0_wr_exp       = 1'b1;
        cp0_clean_exl    = 1'b0;
        cp0_badv_we      = 1'b0;
        exp_code         = EXC_INT;
        exp_bad_vaddr    = '0;
        exp_epc          = in_delayslot ? (pc_value - 32'd4) : pc_value;
        exception_new_pc = exception_base + VEC_GENERAL_OFS;

        if (int_taken) begin
            if (special_int_vec) begin
                exception_new_pc = exception_base + VEC_INT_OFS;
            end
        end else if (iaddr_exp_illegal) begin
            exp_code      = EXC_ADEL;
            exp_bad_vaddr = pc_value;
            cp0_badv_we   = 1'b1;
        end else if (syscall) begin
            exp_code = EXC_SYS;
        end else if (invalid_inst) begin
            exp_code = EXC_RI;
        end else if (eret) begin
            // Return, not an entry
            cp0_wr_exp       = 1'b0;
            cp0_clean_exl    = 1'b1;
            exception_new_pc = epc_in;
        end else if (daddr_exp_illegal) begin
            exp_code      = data_we ? EXC_ADES : EXC_ADEL;
            exp_bad_vaddr = mem_access_vaddr;
            cp0_badv_we   = 1'b1;
        end else begin
            flush      = 1'b0;
            cp0_wr_exp = 1'b0;
        end
    end

endmodule

// File: cp0_regs.sv
`timescale 1ns/1ps

module cp0_regs #(
    parameter mips_exc_pkg::word_t EBASE_RESET = mips_exc_pkg::EBASE_RESET_DEFAULT
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [5:0]               hw_int,
    input  logic                     cp0_we,
    input  mips_exc_pkg::cp0_addr_t  cp0_waddr,
    input  mips_exc_pkg::word_t      cp0_wdata,
    input  logic                     cp0_wr_exp,
    input  logic                     cp0_clean_exl,
    input  logic                     cp0_badv_we,
    input  mips_exc_pkg::exc_code_t  exp_code,
    input  mips_exc_pkg::word_t      exp_epc,
    input  mips_exc_pkg::word_t      exp_bad_vaddr,
    input  logic                     in_delayslot,
    output mips_exc_pkg::word_t      status,
    output mips_exc_pkg::word_t      cause,
    output mips_exc_pkg::word_t      epc,
    output mips_exc_pkg::word_t      badvaddr,
    output mips_exc_pkg::irq_t       interrupt_flags,
    output logic                     allow_int,
    output logic [19:0]              ebase_out,
    output logic                     special_int_vec,
    output logic                     boot_exp_vec
);
    import mips_exc_pkg::*;

    logic      st_bev;
    irq_t      st_im;
    logic      st_exl;
    logic      st_ie;
    logic      ca_bd;
    logic      ca_iv;
    logic [5:0] ca_ip_hw;
    logic [1:0] ca_ip_sw;
    exc_code_t ca_exc_code;
    logic [19:0] ebase_page;
    irq_t      pending;
    logic      sw_write;

    assign sw_write = cp0_we & ~cp0_wr_exp & ~cp0_clean_exl; // Strobes win
    assign pending  = {ca_ip_hw, ca_ip_sw};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st_bev      <= 1'b1;
            st_im       <= '0;
            st_exl      <= 1'b0;
            st_ie       <= 1'b0;
            ca_bd       <= 1'b0;
            ca_iv       <= 1'b0;
            ca_ip_hw    <= '0;
            ca_ip_sw    <= '0;
            ca_exc_code <= EXC_INT;
            epc         <= '0;
            badvaddr    <= '0;
            ebase_page  <= EBASE_RESET[31:12];
        end else begin
            ca_ip_hw <= hw_int; // Sampled every cycle
            if (cp0_wr_exp) begin
                st_exl      <= 1'b1;
                ca_exc_code <= exp_code;
                if (!st_exl) begin // Nested entry keeps EPC and BD
                    epc   <= exp_epc;
                    ca_bd <= in_delayslot;
                end
                if (cp0_badv_we) begin
                    badvaddr <= exp_bad_vaddr;
                end
            end else if (cp0_clean_exl) begin
                st_exl <= 1'b0;
            end else if (sw_write) begin
                case (cp0_waddr)
                    CP0_STATUS: begin
                        st_bev <= cp0_wdata[STATUS_BEV_BIT];
                        st_im  <= cp0_wdata[15:8];
                        st_exl <= cp0_wdata[STATUS_EXL_BIT];
                        st_ie  <= cp0_wdata[STATUS_IE_BIT];
                    end
                    CP0_CAUSE: begin
                        ca_iv    <= cp0_wdata[CAUSE_IV_BIT];
                        ca_ip_sw <= cp0_wdata[9:8];
                    end
                    CP0_EPC:      epc <= cp0_wdata;
                    CP0_EBASE:    ebase_page <= cp0_wdata[31:12];
                    CP0_BADVADDR: ; // Read only
                    default:      ;
                endcase
            end
        end
    end

    assign status = {9'b0, st_bev, 6'b0, st_im, 6'b0, st_exl, st_ie};
    assign cause  = {ca_bd, 7'b0, ca_iv, 7'b0, pending, 1'b0, ca_exc_code, 2'b0};

    assign interrupt_flags = pending & st_im;
    assign allow_int       = st_ie & ~st_exl;
    assign ebase_out       = ebase_page;
    assign special_int_vec = ca_iv;
    assign boot_exp_vec    = st_bev;

endmodule

// File: fetch_pc.sv
`timescale 1ns/1ps

module fetch_pc #(
    parameter mips_exc_pkg::word_t RESET_PC = mips_exc_pkg::RESET_PC_DEFAULT
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 fetch_advance,
    input  logic                 flush,
    input  mips_exc_pkg::word_t  exception_new_pc,
    output mips_exc_pkg::word_t  fetch_pc
);
    import mips_exc_pkg::*;

    word_t pc_next;

    always_comb begin
        if (flush) begin
            pc_next = exception_new_pc; // Redirect beats advance
        end else if (fetch_advance) begin
            pc_next = fetch_pc + 32'd4;
        end else begin
            pc_next = fetch_pc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_pc <= RESET_PC;
        end else begin
            fetch_pc <= pc_next;
        end
    end

endmodule

// File: exc_top.sv
`timescale 1ns/1ps

module exc_top #(
    parameter mips_exc_pkg::word_t RESET_PC    = mips_exc_pkg::RESET_PC_DEFAULT,
    parameter mips_exc_pkg::word_t EBASE_RESET = mips_exc_pkg::EBASE_RESET_DEFAULT
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     inst_valid,
    input  mips_exc_pkg::word_t      pc,
    input  logic                     in_delayslot,
    input  logic                     syscall,
    input  logic                     eret,
    input  logic                     invalid_inst,
    input  logic                     mem_read,
    input  logic                     mem_write,
    input  mips_exc_pkg::size_t      mem_size,
    input  mips_exc_pkg::word_t      mem_vaddr,
    input  logic [5:0]               hw_int,
    input  logic                     cp0_we,
    input  mips_exc_pkg::cp0_addr_t  cp0_waddr,
    input  mips_exc_pkg::word_t      cp0_wdata,
    input  logic                     fetch_advance,
    output logic                     redirect,
    output mips_exc_pkg::word_t      new_pc,
    output mips_exc_pkg::word_t      fetch_pc,
    output mips_exc_pkg::word_t      status,
    output mips_exc_pkg::word_t      cause,
    output mips_exc_pkg::word_t      epc,
    output mips_exc_pkg::word_t      badvaddr
);
    import mips_exc_pkg::*;

    logic      is_real_inst;
    word_t     pc_value;
    logic      in_delayslot_q;
    logic      syscall_q;
    logic      eret_q;
    logic      invalid_inst_q;
    logic      data_we;
    word_t     mem_access_vaddr;
    logic      iaddr_exp_illegal;
    logic      daddr_exp_illegal;
    irq_t      interrupt_flags;
    logic      allow_int;
    logic [19:0] ebase;
    logic      special_int_vec;
    logic      boot_exp_vec;
    logic      cp0_wr_exp;
    logic      cp0_clean_exl;
    logic      cp0_badv_we;
    exc_code_t exp_code;
    word_t     exp_epc;
    word_t     exp_bad_vaddr;

    addr_check u_addr_check (
        .clk               (clk),
        .rst_n             (rst_n),
        .inst_valid        (inst_valid),
        .pc                (pc),
        .in_delayslot      (in_delayslot),
        .syscall           (syscall),
        .eret              (eret),
        .invalid_inst      (invalid_inst),
        .mem_read          (mem_read),
        .mem_write         (mem_write),
        .mem_size          (mem_size),
        .mem_vaddr         (mem_vaddr),
        .is_real_inst      (is_real_inst),
        .pc_value          (pc_value),
        .in_delayslot_q    (in_delayslot_q),
        .syscall_q         (syscall_q),
        .eret_q            (eret_q),
        .invalid_inst_q    (invalid_inst_q),
        .data_we           (data_we),
        .mem_access_vaddr  (mem_access_vaddr),
        .iaddr_exp_illegal (iaddr_exp_illegal),
        .daddr_exp_illegal (daddr_exp_illegal)
    );

    exception u_exception (
        .is_real_inst      (is_real_inst),
        .pc_value          (pc_value),
        .in_delayslot      (in_delayslot_q),
        .syscall           (syscall_q),
        .eret              (eret_q),
        .invalid_inst      (invalid_inst_q),
        .data_we           (data_we),
        .mem_access_vaddr  (mem_access_vaddr),
        .iaddr_exp_illegal (iaddr_exp_illegal),
        .daddr_exp_illegal (daddr_exp_illegal),
        .interrupt_flags   (interrupt_flags),
        .allow_int         (allow_int),
        .ebase_in          (ebase),
        .epc_in            (epc),
        .special_int_vec   (special_int_vec),
        .boot_exp_vec      (boot_exp_vec),
        .flush             (redirect),
        .cp0_wr_exp        (cp0_wr_exp),
        .cp0_clean_exl     (cp0_clean_exl),
        .exp_epc           (exp_epc),
        .exp_code          (exp_code),
        .exp_bad_vaddr     (exp_bad_vaddr),
        .cp0_badv_we       (cp0_badv_we),
        .exception_new_pc  (new_pc)
    );

    cp0_regs #(
        .EBASE_RESET (EBASE_RESET)
    ) u_cp0_regs (
        .clk             (clk),
        .rst_n           (rst_n),
        .hw_int          (hw_int),
        .cp0_we          (cp0_we),
        .cp0_waddr       (cp0_waddr),
        .cp0_wdata       (cp0_wdata),
        .cp0_wr_exp      (cp0_wr_exp),
        .cp0_clean_exl   (cp0_clean_exl),
        .cp0_badv_we     (cp0_badv_we),
        .exp_code        (exp_code),
        .exp_epc         (exp_epc),
        .exp_bad_vaddr   (exp_bad_vaddr),
        .in_delayslot    (in_delayslot_q),
        .status          (status),
        .cause           (cause),
        .epc             (epc),
        .badvaddr        (badvaddr),
        .interrupt_flags (interrupt_flags),
        .allow_int       (allow_int),
        .ebase_out       (ebase),
        .special_int_vec (special_int_vec),
        .boot_exp_vec    (boot_exp_vec)
    );

    fetch_pc #(
        .RESET_PC (RESET_PC)
    ) u_fetch_pc (
        .clk              (clk),
        .rst_n            (rst_n),
        .fetch_advance    (fetch_advance),
        .flush            (redirect),
        .exception_new_pc (new_pc),
        .fetch_pc         (fetch_pc)
    );

endmodule

// File: tb_exc.sv
`timescale 1ns/1ps

module tb_exc;
    import mips_exc_pkg::*;

    localparam word_t RESET_PC    = 32'hBFC0_0400;
    localparam word_t EBASE_RESET = 32'h8004_2000;

    // Model events ranked by priority
    localparam int EV_NONE = 0;
    localparam int EV_DADE = 1;
    localparam int EV_ERET = 2;
    localparam int EV_RI   = 3;
    localparam int EV_SYS  = 4;
    localparam int EV_IADE = 5;
    localparam int EV_INT  = 6;

    logic clk = 1'b0;
    logic rst_n;
    logic inst_valid, in_delayslot, syscall, eret, invalid_inst;
    logic mem_read, mem_write, cp0_we, fetch_advance;
    word_t pc, mem_vaddr, cp0_wdata;
    size_t mem_size;
    logic [5:0] hw_int;
    cp0_addr_t cp0_waddr;
    logic redirect;
    word_t new_pc, fetch_pc, status, cause, epc, badvaddr;

    logic [31:0] lfsr = 32'h6a06_8382;
    int errors = 0;
    int timeouts = 0;
    int n_insts = 0;
    int n_redirects = 0;

    // Model copy of the captured instruction
    logic c_valid, c_ds, c_sys, c_eret, c_ri, c_wr, c_iade, c_dade;
    word_t c_pc, c_vaddr;
    // Model CP0 state and fetch pc
    logic m_bev, m_exl, m_ie, m_bd, m_iv;
    irq_t m_im;
    logic [5:0] m_iphw;
    logic [1:0] m_ipsw;
    exc_code_t m_code;
    word_t m_epc, m_badv, m_ebase, m_fpc;

    int ev;
    logic exp_redirect;
    word_t vec_base, exp_new_pc, exp_status, exp_cause;

    exc_top #(
        .RESET_PC    (RESET_PC),
        .EBASE_RESET (EBASE_RESET)
    ) dut_i (
        .clk (clk), .rst_n (rst_n), .inst_valid (inst_valid), .pc (pc),
        .in_delayslot (in_delayslot), .syscall (syscall), .eret (eret),
        .invalid_inst (invalid_inst), .mem_read (mem_read), .mem_write (mem_write),
        .mem_size (mem_size), .mem_vaddr (mem_vaddr), .hw_int (hw_int),
        .cp0_we (cp0_we), .cp0_waddr (cp0_waddr), .cp0_wdata (cp0_wdata),
        .fetch_advance (fetch_advance), .redirect (redirect), .new_pc (new_pc),
        .fetch_pc (fetch_pc), .status (status), .cause (cause), .epc (epc),
        .badvaddr (badvaddr)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] draw(input int nbits);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int k = 0; k < nbits; k++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic exc_code_t code_of(input int kind, input logic is_store);
        case (kind)
            EV_IADE: return 5'd4;
            EV_DADE: return is_store ? 5'd5 : 5'd4;
            EV_SYS:  return 5'd8;
            EV_RI:   return 5'd10;
            default: return 5'd0;
        endcase
    endfunction

    always_comb begin
        ev = EV_NONE;
        if (c_dade) ev = EV_DADE;
        if (c_eret) ev = EV_ERET;
        if (c_ri) ev = EV_RI;
        if (c_sys) ev = EV_SYS;
        if (c_iade) ev = EV_IADE;
        if (c_valid && m_ie && !m_exl && (({m_iphw, m_ipsw} & m_im) != 8'h00)) ev = EV_INT;
        vec_base     = m_bev ? 32'hBFC0_0200 : m_ebase;
        exp_redirect = (ev != EV_NONE);
        if (ev == EV_ERET) exp_new_pc = m_epc;
        else if (ev == EV_INT && m_iv) exp_new_pc = vec_base + 32'h200;
        else exp_new_pc = vec_base + 32'h180;
        exp_status = '0;
        exp_status[22] = m_bev;
        exp_status[15:8] = m_im;
        exp_status[1] = m_exl;
        exp_status[0] = m_ie;
        exp_cause = '0;
        exp_cause[31] = m_bd;
        exp_cause[23] = m_iv;
        exp_cause[15:8] = {m_iphw, m_ipsw};
        exp_cause[6:2] = m_code;
    end

    always @(posedge clk) begin
        c_pc    <= pc;
        c_vaddr <= mem_vaddr;
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            {c_valid, c_ds, c_sys, c_eret, c_ri, c_wr, c_iade, c_dade} <= '0;
            {m_exl, m_ie, m_bd, m_iv, m_im, m_iphw, m_ipsw, m_code} <= '0;
            m_bev   <= 1'b1;
            m_epc   <= '0;
            m_badv  <= '0;
            m_ebase <= {EBASE_RESET[31:12], 12'h000};
            m_fpc   <= RESET_PC;
        end else begin
            c_valid <= inst_valid;
            c_ds    <= inst_valid & in_delayslot;
            c_sys   <= inst_valid & syscall;
            c_eret  <= inst_valid & eret;
            c_ri    <= inst_valid & invalid_inst;
            c_wr    <= inst_valid & mem_write;
            c_iade  <= inst_valid & (pc[1:0] != 2'b00);
            c_dade  <= inst_valid & (mem_read | mem_write) &
                       ((mem_size == SIZE_HALF && mem_vaddr[0]) ||
                        (mem_size == SIZE_WORD && mem_vaddr[1:0] != 2'b00));
            m_iphw  <= hw_int;
            if (ev != EV_NONE && ev != EV_ERET) begin
                m_exl  <= 1'b1;
                m_code <= code_of(ev, c_wr);
                if (!m_exl) begin
                    m_epc <= c_ds ? c_pc - 32'd4 : c_pc;
                    m_bd  <= c_ds;
                end
                if (ev == EV_IADE) m_badv <= c_pc;
                if (ev == EV_DADE) m_badv <= c_vaddr;
            end else if (ev == EV_ERET) begin
                m_exl <= 1'b0;
            end else if (cp0_we) begin
                case (cp0_waddr)
                    5'd12: {m_bev, m_im, m_exl, m_ie} <=
                               {cp0_wdata[22], cp0_wdata[15:8], cp0_wdata[1], cp0_wdata[0]};
                    5'd13: {m_iv, m_ipsw} <= {cp0_wdata[23], cp0_wdata[9:8]};
                    5'd14: m_epc <= cp0_wdata;
                    5'd15: m_ebase <= {cp0_wdata[31:12], 12'h000};
                    default: ;
                endcase
            end
            if (exp_redirect) m_fpc <= exp_new_pc;
            else if (fetch_advance) m_fpc <= m_fpc + 32'd4;
            if (inst_valid) n_insts <= n_insts + 1;
            if (exp_redirect) n_redirects <= n_redirects + 1;
        end
    end

    task automatic flag_mismatch(input string what);
        $display("Error %0t: %s differs from the model", $time, what);
        errors++;
    endtask

    a_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        redirect == exp_redirect) else flag_mismatch("redirect");
    a_new_pc: assert property (@(posedge clk) disable iff (!rst_n)
        !exp_redirect || new_pc == exp_new_pc) else flag_mismatch("new_pc");
    a_fetch_pc: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_pc == m_fpc) else flag_mismatch("fetch_pc");
    a_status: assert property (@(posedge clk) disable iff (!rst_n)
        status == exp_status) else flag_mismatch("Status");
    a_cause: assert property (@(posedge clk) disable iff (!rst_n)
        cause == exp_cause) else flag_mismatch("Cause");
    a_epc: assert property (@(posedge clk) disable iff (!rst_n)
        epc == m_epc) else flag_mismatch("EPC");
    a_badvaddr: assert property (@(posedge clk) disable iff (!rst_n)
        badvaddr == m_badv) else flag_mismatch("BadVAddr");

    task automatic check_word(input word_t actual, input word_t expected, input string what);
        assert (actual == expected) else begin
            $display("Error %0t: %s is %h, expected %h", $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic clear_inst();
        {inst_valid, in_delayslot, syscall, eret, invalid_inst, mem_read, mem_write} = '0;
        pc        = '0;
        mem_size  = SIZE_BYTE;
        mem_vaddr = '0;
    endtask

    task automatic prep();
        @(posedge clk);
        #1;
        clear_inst();
    endtask

    // Pulse one instruction and look for the redirect it should cause
    task automatic fire(input logic taken, input word_t target);
        int n;
        inst_valid = 1'b1;
        @(posedge clk);
        #1;
        clear_inst();
        @(negedge clk);
        n = 1;
        while (taken && !redirect && n < 4) begin
            @(negedge clk);
            n++;
        end
        if (taken && !redirect) begin
            $display("No redirect appeared within 4 cycles of an excepting instruction");
            timeouts++;
        end else if (taken) begin
            check_word(new_pc, target, "new_pc");
        end else begin
            check_word(32'(redirect), 32'd0, "redirect");
        end
        @(negedge clk); // CP0 has committed here
    endtask

    task automatic do_eret(input word_t target);
        prep();
        hw_int = '0;
        pc     = 32'h0000_0100;
        eret   = 1'b1;
        fire(1'b1, target);
        check_word(32'(status[1]), 32'd0, "Status.EXL after ERET");
    endtask

    task automatic cp0_write(input cp0_addr_t addr, input word_t data);
        @(posedge clk);
        #1;
        cp0_we    = 1'b1;
        cp0_waddr = addr;
        cp0_wdata = data;
        @(posedge clk);
        #1;
        cp0_we = 1'b0;
    endtask

    task automatic drive_random();
        inst_valid    = draw(1) == 1;
        pc            = {30'(draw(30)), 2'b00};
        if (draw(3) == 0) pc[1:0] = 2'(draw(2));
        in_delayslot  = draw(2) == 0;
        syscall       = draw(3) == 0;
        eret          = draw(3) == 0;
        invalid_inst  = draw(3) == 0;
        mem_read      = draw(1) == 1;
        mem_write     = !mem_read && draw(1) == 1;
        case (draw(2))
            0: mem_size = SIZE_BYTE;
            1: mem_size = SIZE_HALF;
            default: mem_size = SIZE_WORD;
        endcase
        mem_vaddr     = draw(32);
        fetch_advance = draw(1) == 1;
        if (draw(4) == 0) hw_int = 6'(draw(6));
        cp0_we    = draw(3) == 0;
        case (draw(2))
            0: cp0_waddr = CP0_STATUS;
            1: cp0_waddr = CP0_CAUSE;
            2: cp0_waddr = CP0_EPC;
            default: cp0_waddr = (draw(1) == 1) ? CP0_EBASE : CP0_BADVADDR;
        endcase
        cp0_wdata = draw(32);
    endtask

    initial begin
        rst_n = 1'b0;
        clear_inst();
        hw_int = '0;
        {cp0_we, fetch_advance} = '0;
        cp0_waddr = '0;
        cp0_wdata = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_word(fetch_pc, RESET_PC, "fetch_pc after reset");
        check_word(status, 32'h0040_0000, "Status after reset");
        check_word(32'(redirect), 32'd0, "redirect after reset");

        prep();
        pc      = 32'h1000;
        syscall = 1'b1;
        fire(1'b1, 32'hBFC0_0380);
        check_word(32'(cause[6:2]), 32'd8, "Cause.ExcCode");
        check_word(epc, 32'h1000, "EPC");
        do_eret(32'h1000);
        check_word(32'(cause[6:2]), 32'd8, "Cause.ExcCode after ERET");
        prep();
        pc           = 32'h2004;
        in_delayslot = 1'b1;
        invalid_inst = 1'b1;
        fire(1'b1, 32'hBFC0_0380);
        check_word({cause[31], 26'd0, cause[6:2]}, {1'b1, 26'd0, 5'd10}, "Cause.BD and ExcCode");
        check_word(epc, 32'h2000, "EPC in delay slot");
        prep();
        pc      = 32'h3000;
        syscall = 1'b1;
        fire(1'b1, 32'hBFC0_0380);
        check_word(epc, 32'h2000, "EPC on nested exception");
        prep();
        pc        = 32'h3004;
        eret      = 1'b1;
        mem_read  = 1'b1;
        mem_size  = SIZE_WORD;
        mem_vaddr = 32'h7777_0001;
        fire(1'b1, 32'h2000);
        check_word(badvaddr, 32'h0, "BadVAddr after ERET with data error");

        // Address errors
        prep();
        pc      = 32'h4002;
        syscall = 1'b1;
        fire(1'b1, 32'hBFC0_0380);
        check_word({badvaddr[15:0], 11'd0, cause[6:2]}, {16'h4002, 11'd0, 5'd4}, "fetch AdEL");
        do_eret(32'h4002);
        prep();
        pc        = 32'h5000;
        mem_read  = 1'b1;
        mem_size  = SIZE_HALF;
        mem_vaddr = 32'h5001;
        fire(1'b1, 32'hBFC0_0380);
        check_word({badvaddr[15:0], 11'd0, cause[6:2]}, {16'h5001, 11'd0, 5'd4}, "half AdEL");
        do_eret(32'h5000);
        prep();
        pc        = 32'h5004;
        mem_read  = 1'b1;
        mem_size  = SIZE_WORD;
        mem_vaddr = 32'h5002;
        fire(1'b1, 32'hBFC0_0380);
        check_word({badvaddr[15:0], 11'd0, cause[6:2]}, {16'h5002, 11'd0, 5'd4}, "word AdEL");
        do_eret(32'h5004);
        prep();
        pc        = 32'h6000;
        mem_write = 1'b1;
        mem_size  = SIZE_WORD;
        mem_vaddr = 32'h6002;
        fire(1'b1, 32'hBFC0_0380);
        check_word({badvaddr[15:0], 11'd0, cause[6:2]}, {16'h6002, 11'd0, 5'd5}, "word AdES");
        do_eret(32'h6000);
        prep();
        pc        = 32'h6004;
        mem_write = 1'b1;
        mem_vaddr = 32'h6003;
        fire(1'b0, '0);

        cp0_write(CP0_STATUS, 32'h0); // BEV off with EBase at its reset value
        prep();
        pc      = 32'h8000;
        syscall = 1'b1;
        fire(1'b1, EBASE_RESET + 32'h180);
        do_eret(32'h8000);

        // Interrupts on IP2
        cp0_write(CP0_EBASE, 32'h9000_0000);
        cp0_write(CP0_CAUSE, 32'h0080_0000);
        cp0_write(CP0_STATUS, 32'h0000_0401);
        prep();
        hw_int = 6'b000001;
        pc     = 32'h7000;
        fire(1'b1, 32'h9000_0200);
        check_word(32'(cause[6:2]), 32'd0, "Cause.ExcCode for interrupt");
        prep();
        pc = 32'h7004;
        fire(1'b0, '0);
        do_eret(32'h7000);
        cp0_write(CP0_CAUSE, 32'h0);
        prep();
        hw_int = 6'b000001;
        pc     = 32'h7100;
        fire(1'b1, 32'h9000_0180);
        do_eret(32'h7100);
        cp0_write(CP0_STATUS, 32'h0000_0001);
        prep();
        hw_int = 6'b000001;
        pc     = 32'h7200;
        fire(1'b0, '0);
        prep();
        hw_int = '0;

        for (int i = 0; i < 600; i++) begin
            @(posedge clk);
            #1;
            drive_random();
        end
        @(posedge clk);
        #1;
        clear_inst();
        cp0_we = 1'b0;
        repeat (3) @(posedge clk);

        $display("Instructions %0d, redirects %0d, errors %0d, timeouts %0d",
                 n_insts, n_redirects, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        #200000;
        $display("Simulation ran past its time limit without finishing");
        $display("Verification failed");
        $finish;
    end

endmodule

// File: vlog.f
mips_exc_pkg.sv
addr_check.sv
exception.sv
cp0_regs.sv
fetch_pc.sv
exc_top.sv
tb_exc.sv

// File: Makefile
TOP = tb_exc

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
